// ==== rv32_decode_top.f ====
+incdir+verilog
+incdir+test
verilog/rv32_pkg.sv
verilog/fetch_aligner.sv
verilog/inst_decoder.sv
verilog/decode_queue.sv
verilog/rv32_decode_top.sv
test/tb_rv32_decode_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module tb_rv32_decode_top \
        -f rv32_decode_top.f -o tb_sim \
    && ./obj_dir/tb_sim \
    || exit 1

// ==== test/tb_rv32_decode_ref.svh ====
`ifndef TB_RV32_DECODE_REF_SVH
`define TB_RV32_DECODE_REF_SVH

typedef struct packed {
    word_t    pc;
    openum_t  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    logic     jump;
} exp_op_t;

// Expected result of one slot, straight from the RV32I encoding rules
function automatic exp_op_t ref_decode(word_t inst, word_t pc);
    exp_op_t e;
    logic [2:0] f3;
    word_t      i_imm;
    f3     = inst[14:12];
    i_imm  = {{20{inst[31]}}, inst[31:20]};
    e.pc   = pc;
    e.op   = OPENUM_NOP;
    e.rd   = inst[11:7];
    e.rs1  = inst[19:15];
    e.rs2  = inst[24:20];
    e.imm  = '0;
    e.jump = 1'b0;
    case (inst[6:0])
        `OPCODE_LUI: begin
            e.op  = OPENUM_LUI;
            e.imm = {inst[31:12], 12'h000};
        end
        `OPCODE_AUIPC: begin
            e.op  = OPENUM_AUIPC;
            e.imm = {inst[31:12], 12'h000};
        end
        `OPCODE_JAL: begin
            e.op   = OPENUM_JAL;
            e.imm  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            e.jump = 1'b1;
        end
        `OPCODE_JALR: begin
            e.op   = OPENUM_JALR;
            e.imm  = i_imm;
            e.jump = 1'b1;
        end
        `OPCODE_BR: begin
            e.rd   = '0;
            e.imm  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            e.jump = 1'b1;
            case (f3)
                3'b000:  e.op = OPENUM_BEQ;
                3'b001:  e.op = OPENUM_BNE;
                3'b100:  e.op = OPENUM_BLT;
                3'b101:  e.op = OPENUM_BGE;
                3'b110:  e.op = OPENUM_BLTU;
                3'b111:  e.op = OPENUM_BGEU;
                default: e.op = OPENUM_NOP;
            endcase
        end
        `OPCODE_L: begin
            e.imm = i_imm;
            case (f3)
                3'b000:  e.op = OPENUM_LB;
                3'b001:  e.op = OPENUM_LH;
                3'b010:  e.op = OPENUM_LW;
                3'b100:  e.op = OPENUM_LBU;
                3'b101:  e.op = OPENUM_LHU;
                default: e.op = OPENUM_NOP;
            endcase
        end
        `OPCODE_S: begin
            e.rd  = '0;
            e.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            case (f3)
                3'b000:  e.op = OPENUM_SB;
                3'b001:  e.op = OPENUM_SH;
                3'b010:  e.op = OPENUM_SW;
                default: e.op = OPENUM_NOP;
            endcase
        end
        `OPCODE_ARITHI: begin
            e.imm = i_imm;
            case (f3)
                3'b000: e.op = OPENUM_ADDI;
                3'b010: e.op = OPENUM_SLTI;
                3'b011: e.op = OPENUM_SLTIU;
                3'b100: e.op = OPENUM_XORI;
                3'b110: e.op = OPENUM_ORI;
                3'b111: e.op = OPENUM_ANDI;
                default: begin
                    e.imm = {27'b0, inst[24:20]}; // Shamt only
                    if (f3 == 3'b001) begin
                        e.op = OPENUM_SLLI;
                    end else begin
                        e.op = inst[30] ? OPENUM_SRAI : OPENUM_SRLI;
                    end
                end
            endcase
        end
        `OPCODE_ARITH: begin
            case (f3)
                3'b000:  e.op = inst[30] ? OPENUM_SUB : OPENUM_ADD;
                3'b001:  e.op = OPENUM_SLL;
                3'b010:  e.op = OPENUM_SLT;
                3'b011:  e.op = OPENUM_SLTU;
                3'b100:  e.op = OPENUM_XOR;
                3'b101:  e.op = inst[30] ? OPENUM_SRA : OPENUM_SRL;
                3'b110:  e.op = OPENUM_OR;
                default: e.op = OPENUM_AND;
            endcase
        end
        default: e.op = OPENUM_NOP;
    endcase
    return e;
endfunction

function automatic logic is_known(logic [6:0] op);
    case (op)
        `OPCODE_LUI, `OPCODE_AUIPC, `OPCODE_JAL, `OPCODE_JALR, `OPCODE_BR,
        `OPCODE_L, `OPCODE_S, `OPCODE_ARITHI, `OPCODE_ARITH: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// Random instruction of a random format
function automatic word_t gen_inst();
    word_t       inst;
    word_t       r;
    int unsigned kind;
    inst = $random(seed);
    r    = $random(seed);
    kind = {24'b0, r[7:0]} % 32'd11;
    case (kind)
        0: inst[6:0] = `OPCODE_LUI;
        1: inst[6:0] = `OPCODE_AUIPC;
        2: inst[6:0] = `OPCODE_JAL;
        3: begin
            inst[6:0]   = `OPCODE_JALR;
            inst[14:12] = 3'b000;
        end
        4: begin
            inst[6:0]   = `OPCODE_BR;
            inst[14:12] = (r[10:9] == 2'b01) ? {1'b1, r[9:8]} : r[10:8];
        end
        5: begin
            inst[6:0]   = `OPCODE_L;
            inst[14:12] = r[10] ? {1'b1, 1'b0, r[8]} : {1'b0, r[9] & ~r[8], r[8]};
        end
        6: begin
            inst[6:0]   = `OPCODE_S;
            inst[14:12] = {1'b0, r[9] & ~r[8], r[8]};
        end
        7: begin
            inst[6:0]   = `OPCODE_ARITHI;
            inst[14:12] = r[10:8];
            if (r[9:8] == 2'b01) begin
                inst[31:25] = {1'b0, r[11] & r[10], 5'b0}; // SLLI, SRLI or SRAI
            end
        end
        8: begin
            inst[6:0]   = `OPCODE_ARITH;
            inst[14:12] = r[10:8];
            inst[31:25] = (r[9:8] == 2'b00 || r[10:8] == 3'b101) ? {1'b0, r[11], 5'b0} : 7'b0;
        end
        9: inst[6:0] = is_known(r[20:14]) ? 7'b1111111 : r[20:14];
        default: begin // Known opcode with an unlisted func3
            if (r[11]) begin
                inst[6:0]   = `OPCODE_BR;
                inst[14:12] = {2'b01, r[12]};
            end else begin
                inst[6:0]   = r[12] ? `OPCODE_L : `OPCODE_S;
                inst[14:12] = {r[13], 2'b11};
            end
        end
    endcase
    return inst;
endfunction

task automatic check_openum(string name, openum_t want, openum_t got);
    if (got !== want) begin
        abort_run($sformatf("[ERROR] %0t %s expected %s actual %s",
                            $time, name, want.name(), got.name()));
    end
endtask

task automatic check_reg(string name, reg_idx_t want, reg_idx_t got);
    if (got !== want) begin
        abort_run($sformatf("[ERROR] %0t %s expected %0d actual %0d", $time, name, want, got));
    end
endtask

task automatic check_word(string name, word_t want, word_t got);
    if (got !== want) begin
        abort_run($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, want, got));
    end
endtask

task automatic check_bit(string name, logic want, logic got);
    if (got !== want) begin
        abort_run($sformatf("[ERROR] %0t %s expected %b actual %b", $time, name, want, got));
    end
endtask

`endif

// ==== test/tb_rv32_decode_top.sv ====
`timescale 1ns/1ps
`include "rv32_defs.svh"

module tb_rv32_decode_top import rv32_pkg::*; ();

    localparam int NUM_PKTS     = 400;
    localparam int WATCHDOG_NS  = NUM_PKTS * 2 * 10 * 20;
    localparam int DRAIN_CYCLES = 10 * (`QUEUE_DEPTH + `FETCH_WIDTH);
    localparam int STALL_AT     = `QUEUE_DEPTH - 2 * `FETCH_WIDTH;

    logic                     clk;
    logic                     arst_n;
    logic                     fetch_valid;
    word_t                    fetch_pc;
    word_t [`FETCH_WIDTH-1:0] fetch_insts;
    logic                     issue_stall;
    logic                     fetch_stall;
    logic                     issue_valid;
    word_t                    issue_pc;
    openum_t                  issue_openum;
    reg_idx_t                 issue_rd;
    reg_idx_t                 issue_rs1;
    reg_idx_t                 issue_rs2;
    word_t                    issue_imm;
    logic                     issue_is_jump;

    integer seed;
    int     pkt_ops;    // Surviving operations of the packet being strobed
    int     in_aligner; // Operations waiting in the aligner
    int     held;       // Operations held in the DUT queue

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "Run stopped");
    endtask

    `include "tb_rv32_decode_ref.svh"

    exp_op_t exp_q[$]; // Operations still to be issued, oldest first

    rv32_decode_top uut (
        .clk           (clk),
        .arst_n        (arst_n),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .fetch_insts   (fetch_insts),
        .issue_stall   (issue_stall),
        .fetch_stall   (fetch_stall),
        .issue_valid   (issue_valid),
        .issue_pc      (issue_pc),
        .issue_openum  (issue_openum),
        .issue_rd      (issue_rd),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_imm     (issue_imm),
        .issue_is_jump (issue_is_jump)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("Timeout: run did not finish within %0d ns", WATCHDOG_NS));
    end

    // Drive one packet and queue its surviving operations
    task automatic send_packet();
        word_t   r;
        word_t   base;
        word_t   addr;
        exp_op_t e;
        logic    cut;
        r    = $random(seed);
        base = {r[31:3], 3'b000};
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            fetch_insts[i] = gen_inst();
        end
        fetch_pc    = {r[31:3], r[0], 2'b00}; // Bit 2 picks the entry slot
        fetch_valid = 1'b1;
        cut         = 1'b0;
        pkt_ops     = 0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            addr = base + word_t'(4 * i);
            if (addr >= fetch_pc && !cut) begin
                e = ref_decode(fetch_insts[i], addr);
                exp_q.push_back(e);
                pkt_ops++;
                cut = e.jump;
            end
        end
    endtask

    initial begin : stimulus
        word_t r;
        int    sent;
        int    waited;
        seed        = 32'hac6be917;
        sent        = 0;
        waited      = 0;
        pkt_ops     = 0;
        in_aligner  = 0;
        held        = 0;
        arst_n      = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        fetch_insts = '0;
        issue_stall = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_bit("issue_valid", 1'b0, issue_valid);
        check_bit("fetch_stall", 1'b0, fetch_stall);
        while (sent < NUM_PKTS) begin
            @(negedge clk);
            r           = $random(seed);
            issue_stall = (r[7:0] < 8'd102); // About 40 percent
            fetch_valid = 1'b0;
            if (!fetch_stall && r[8]) begin
                send_packet();
                sent++;
            end
        end
        while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            r           = $random(seed);
            issue_stall = (r[7:0] < 8'd102);
            fetch_valid = 1'b0;
            waited++;
        end
        @(negedge clk);
        fetch_valid = 1'b0;
        issue_stall = 1'b0;
        repeat (4) @(negedge clk);
        if (exp_q.size() != 0 || issue_valid) begin
            abort_run("Queue not drained at end of run");
        end else begin
            $display("No errors");
            $finish;
        end
    end

    // Occupancy follows the strobe by one edge into the aligner and one more into the queue
    always @(posedge clk) begin : scoreboard
        exp_op_t want;
        logic    pop;
        if (arst_n) begin
            pop = (held != 0) && !issue_stall;
            check_bit("issue_valid", held != 0, issue_valid);
            check_bit("fetch_stall", held > STALL_AT, fetch_stall);
            if (pop) begin
                want = exp_q.pop_front();
                check_word("issue_pc", want.pc, issue_pc);
                check_openum("issue_openum", want.op, issue_openum);
                check_reg("issue_rd", want.rd, issue_rd);
                check_reg("issue_rs1", want.rs1, issue_rs1);
                check_reg("issue_rs2", want.rs2, issue_rs2);
                check_word("issue_imm", want.imm, issue_imm);
                check_bit("issue_is_jump", want.jump, issue_is_jump);
            end
            held       = held + in_aligner - (pop ? 1 : 0);
            in_aligner = fetch_valid ? pkt_ops : 0;
        end
    end

endmodule

// ==== verilog/rv32_decode_top.sv ====
`timescale 1ns/1ps
`include "rv32_defs.svh"

module rv32_decode_top import rv32_pkg::*; (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        fetch_valid,
    input  word_t                       fetch_pc,
    input  word_t [`FETCH_WIDTH-1:0]    fetch_insts,
    input  logic                        issue_stall,
    output logic                        fetch_stall,
    output logic                        issue_valid,
    output word_t                       issue_pc,
    output openum_t                     issue_openum,
    output reg_idx_t                    issue_rd,
    output reg_idx_t                    issue_rs1,
    output reg_idx_t                    issue_rs2,
    output word_t                       issue_imm,
    output logic                        issue_is_jump
);

    logic     [`FETCH_WIDTH-1:0] slot_valid;
    word_t    [`FETCH_WIDTH-1:0] slot_inst;
    word_t    [`FETCH_WIDTH-1:0] slot_pc;
    openum_t  [`FETCH_WIDTH-1:0] dec_openum;
    reg_idx_t [`FETCH_WIDTH-1:0] dec_rd;
    reg_idx_t [`FETCH_WIDTH-1:0] dec_rs1;
    reg_idx_t [`FETCH_WIDTH-1:0] dec_rs2;
    word_t    [`FETCH_WIDTH-1:0] dec_imm;
    logic     [`FETCH_WIDTH-1:0] dec_is_jump;

    fetch_aligner u_aligner (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_insts (fetch_insts),
        .slot_valid  (slot_valid),
        .slot_inst   (slot_inst),
        .slot_pc     (slot_pc)
    );

    for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : g_dec
        inst_decoder u_dec (
            .inst    (slot_inst[i]),
            .openum  (dec_openum[i]),
            .rd      (dec_rd[i]),
            .rs1     (dec_rs1[i]),
            .rs2     (dec_rs2[i]),
            .imm     (dec_imm[i]),
            .is_jump (dec_is_jump[i])
        );
    end

    decode_queue u_queue (
        .clk           (clk),
        .arst_n        (arst_n),
        .slot_valid    (slot_valid),
        .slot_pc       (slot_pc),
        .dec_openum    (dec_openum),
        .dec_rd        (dec_rd),
        .dec_rs1       (dec_rs1),
        .dec_rs2       (dec_rs2),
        .dec_imm       (dec_imm),
        .dec_is_jump   (dec_is_jump),
        .issue_stall   (issue_stall),
        .fetch_stall   (fetch_stall),
        .issue_valid   (issue_valid),
        .issue_pc      (issue_pc),
        .issue_openum  (issue_openum),
        .issue_rd      (issue_rd),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_imm     (issue_imm),
        .issue_is_jump (issue_is_jump)
    );

endmodule

// ==== verilog/decode_queue.sv ====
`timescale 1ns/1ps
`include "rv32_defs.svh"

module decode_queue import rv32_pkg::*; (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic     [`FETCH_WIDTH-1:0]       slot_valid,
    input  word_t    [`FETCH_WIDTH-1:0]       slot_pc,
    input  openum_t  [`FETCH_WIDTH-1:0]       dec_openum,
    input  reg_idx_t [`FETCH_WIDTH-1:0]       dec_rd,
    input  reg_idx_t [`FETCH_WIDTH-1:0]       dec_rs1,
    input  reg_idx_t [`FETCH_WIDTH-1:0]       dec_rs2,
    input  word_t    [`FETCH_WIDTH-1:0]       dec_imm,
    input  logic     [`FETCH_WIDTH-1:0]       dec_is_jump,
    input  logic                              issue_stall,
    output logic                              fetch_stall,
    output logic                              issue_valid,
    output word_t                             issue_pc,
    output openum_t                           issue_openum,
    output reg_idx_t                          issue_rd,
    output reg_idx_t                          issue_rs1,
    output reg_idx_t                          issue_rs2,
    output word_t                             issue_imm,
    output logic                              issue_is_jump
);

    localparam int unsigned AW = $clog2(`QUEUE_DEPTH);
    localparam logic [AW:0] STALL_LVL = (AW + 1)'(`QUEUE_DEPTH - 2 * `FETCH_WIDTH);

    word_t    q_pc   [`QUEUE_DEPTH];
    openum_t  q_op   [`QUEUE_DEPTH];
    reg_idx_t q_rd   [`QUEUE_DEPTH];
    reg_idx_t q_rs1  [`QUEUE_DEPTH];
    reg_idx_t q_rs2  [`QUEUE_DEPTH];
    word_t    q_imm  [`QUEUE_DEPTH];
    logic     q_jump [`QUEUE_DEPTH];

    logic [AW-1:0]           wr_ptr;
    logic [AW-1:0]           rd_ptr;
    logic [AW:0]             count;
    logic [AW:0]             n_wr;
    logic [`FETCH_WIDTH-1:0] keep;
    logic [AW-1:0]           wr_idx [`FETCH_WIDTH];
    logic                    cut;
    logic                    pop;

    // Compact surviving slots; nothing after a jump is kept
    always_comb begin
        n_wr = '0;
        cut  = 1'b0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            keep[i]   = slot_valid[i] && !cut;
            wr_idx[i] = wr_ptr + n_wr[AW-1:0];
            if (keep[i]) begin
                n_wr = n_wr + 1'b1;
            end
            if (slot_valid[i] && dec_is_jump[i]) begin
                cut = 1'b1;
            end
        end
    end

    assign issue_valid = (count != '0);
    assign pop         = issue_valid && !issue_stall;
    assign fetch_stall = (count > STALL_LVL); // Room for two more packets

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + n_wr[AW-1:0];
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + n_wr - {{AW{1'b0}}, pop};
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (keep[i]) begin
                q_pc[wr_idx[i]]   <= slot_pc[i];
                q_op[wr_idx[i]]   <= dec_openum[i];
                q_rd[wr_idx[i]]   <= dec_rd[i];
                q_rs1[wr_idx[i]]  <= dec_rs1[i];
                q_rs2[wr_idx[i]]  <= dec_rs2[i];
                q_imm[wr_idx[i]]  <= dec_imm[i];
                q_jump[wr_idx[i]] <= dec_is_jump[i];
            end
        end
    end

    assign issue_pc      = q_pc[rd_ptr]; // Head entry
    assign issue_openum  = q_op[rd_ptr];
    assign issue_rd      = q_rd[rd_ptr];
    assign issue_rs1     = q_rs1[rd_ptr];
    assign issue_rs2     = q_rs2[rd_ptr];
    assign issue_imm     = q_imm[rd_ptr];
    assign issue_is_jump = q_jump[rd_ptr];

endmodule

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/1ps
`include "rv32_defs.svh"

module inst_decoder import rv32_pkg::*; (
    input  word_t    inst,
    output openum_t  openum,
    output reg_idx_t rd,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output word_t    imm,
    output logic     is_jump
);

    logic [2:0] func3;
    logic       alt;

    assign func3 = inst[`FUNC3_RANGE];
    assign alt   = inst[`FUNC7_ALT_BIT]; // Selects SUB and arithmetic shift

    always_comb begin
        openum  = OPENUM_NOP;
        rd      = inst[`RD_RANGE];
        rs1     = inst[`RS1_RANGE];
        rs2     = inst[`RS2_RANGE];
        imm     = '0;
        is_jump = 1'b0;

        case (inst[`OPCODE_RANGE])
            `OPCODE_LUI: begin
                openum = OPENUM_LUI;
                imm    = {inst[31:12], 12'b0};
            end
            `OPCODE_AUIPC: begin
                openum = OPENUM_AUIPC;
                imm    = {inst[31:12], 12'b0};
            end
            `OPCODE_JAL: begin
                openum  = OPENUM_JAL;
                imm     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                is_jump = 1'b1;
            end
            `OPCODE_JALR: begin
                openum  = OPENUM_JALR;
                imm     = {{21{inst[31]}}, inst[30:20]};
                is_jump = 1'b1;
            end
            `OPCODE_L: begin
                imm = {{21{inst[31]}}, inst[30:20]};
                case (func3)
                    `FUNC3_LB:  openum = OPENUM_LB;
                    `FUNC3_LH:  openum = OPENUM_LH;
                    `FUNC3_LW:  openum = OPENUM_LW;
                    `FUNC3_LBU: openum = OPENUM_LBU;
                    `FUNC3_LHU: openum = OPENUM_LHU;
                    default:    openum = OPENUM_NOP;
                endcase
            end
            `OPCODE_ARITHI: begin
                imm = {{21{inst[31]}}, inst[30:20]};
                case (func3)
                    `FUNC3_ADD:  openum = OPENUM_ADDI;
                    `FUNC3_SLT:  openum = OPENUM_SLTI;
                    `FUNC3_SLTU: openum = OPENUM_SLTIU;
                    `FUNC3_XOR:  openum = OPENUM_XORI;
                    `FUNC3_OR:   openum = OPENUM_ORI;
                    `FUNC3_AND:  openum = OPENUM_ANDI;
                    `FUNC3_SLL: begin
                        openum = OPENUM_SLLI;
                        imm    = {27'b0, inst[`SHAMT_RANGE]}; // Shift amount only
                    end
                    default: begin
                        if (alt) begin
                            openum = OPENUM_SRAI;
                        end else begin
                            openum = OPENUM_SRLI;
                        end
                        imm = {27'b0, inst[`SHAMT_RANGE]};
                    end
                endcase
            end
            `OPCODE_BR: begin
                rd      = '0; // No destination
                imm     = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                is_jump = 1'b1;
                case (func3)
                    `FUNC3_BEQ:  openum = OPENUM_BEQ;
                    `FUNC3_BNE:  openum = OPENUM_BNE;
                    `FUNC3_BLT:  openum = OPENUM_BLT;
                    `FUNC3_BGE:  openum = OPENUM_BGE;
                    `FUNC3_BLTU: openum = OPENUM_BLTU;
                    `FUNC3_BGEU: openum = OPENUM_BGEU;
                    default:     openum = OPENUM_NOP;
                endcase
            end
            `OPCODE_S: begin
                rd  = '0;
                imm = {{21{inst[31]}}, inst[30:25], inst[`RD_RANGE]};
                case (func3)
                    `FUNC3_SB: openum = OPENUM_SB;
                    `FUNC3_SH: openum = OPENUM_SH;
                    `FUNC3_SW: openum = OPENUM_SW;
                    default:   openum = OPENUM_NOP;
                endcase
            end
            `OPCODE_ARITH: begin
                case (func3)
                    `FUNC3_ADD: begin
                        if (alt) begin
                            openum = OPENUM_SUB;
                        end else begin
                            openum = OPENUM_ADD;
                        end
                    end
                    `FUNC3_SR: begin
                        if (alt) begin
                            openum = OPENUM_SRA;
                        end else begin
                            openum = OPENUM_SRL;
                        end
                    end
                    `FUNC3_SLL:  openum = OPENUM_SLL;
                    `FUNC3_SLT:  openum = OPENUM_SLT;
                    `FUNC3_SLTU: openum = OPENUM_SLTU;
                    `FUNC3_XOR:  openum = OPENUM_XOR;
                    `FUNC3_OR:   openum = OPENUM_OR;
                    default:     openum = OPENUM_AND;
                endcase
            end
            default: begin
                openum = OPENUM_NOP; // Unknown opcode
                imm    = '0;
            end
        endcase
    end

endmodule

// ==== verilog/fetch_aligner.sv ====
`timescale 1ns/1ps
`include "rv32_defs.svh"

module fetch_aligner import rv32_pkg::*; (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           fetch_valid,
    input  word_t                          fetch_pc,
    input  word_t [`FETCH_WIDTH-1:0]       fetch_insts,
    output logic  [`FETCH_WIDTH-1:0]       slot_valid,
    output word_t [`FETCH_WIDTH-1:0]       slot_inst,
    output word_t [`FETCH_WIDTH-1:0]       slot_pc
);

    localparam word_t PKT_MASK = word_t'(`FETCH_WIDTH * 4 - 1);

    word_t                    pkt_base;
    word_t [`FETCH_WIDTH-1:0] addr;
    logic  [`FETCH_WIDTH-1:0] in_pkt;

    assign pkt_base = fetch_pc & ~PKT_MASK; // Packet aligned base

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            addr[i]   = pkt_base + word_t'(4 * i);
            in_pkt[i] = (addr[i] >= fetch_pc); // Drop slots before entry PC
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_valid <= '0;
        end else if (fetch_valid) begin
            slot_valid <= in_pkt;
        end else begin
            slot_valid <= '0; // One cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            slot_inst <= fetch_insts;
            slot_pc   <= addr;
        end
    end

endmodule

// ==== verilog/rv32_pkg.sv ====
package rv32_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [5:0] {
        OPENUM_NOP,
        OPENUM_LUI,
        OPENUM_AUIPC,
        OPENUM_JAL,
        OPENUM_JALR,
        OPENUM_BEQ,
        OPENUM_BNE,
        OPENUM_BLT,
        OPENUM_BGE,
        OPENUM_BLTU,
        OPENUM_BGEU,
        OPENUM_LB,
        OPENUM_LH,
        OPENUM_LW,
        OPENUM_LBU,
        OPENUM_LHU,
        OPENUM_SB,
        OPENUM_SH,
        OPENUM_SW,
        OPENUM_ADDI,
        OPENUM_SLTI,
        OPENUM_SLTIU,
        OPENUM_XORI,
        OPENUM_ORI,
        OPENUM_ANDI,
        OPENUM_SLLI,
        OPENUM_SRLI,
        OPENUM_SRAI,
        OPENUM_ADD,
        OPENUM_SUB,
        OPENUM_SLL,
        OPENUM_SLT,
        OPENUM_SLTU,
        OPENUM_XOR,
        OPENUM_SRL,
        OPENUM_SRA,
        OPENUM_OR,
        OPENUM_AND
    } openum_t;

endpackage

// ==== verilog/rv32_defs.svh ====
`ifndef RV32_DEFS_SVH
`define RV32_DEFS_SVH

// Fetch and queue sizing
`define FETCH_WIDTH 2
`define QUEUE_DEPTH 8

// Instruction field ranges
`define OPCODE_RANGE  6:0
`define RD_RANGE      11:7
`define FUNC3_RANGE   14:12
`define RS1_RANGE     19:15
`define RS2_RANGE     24:20
`define SHAMT_RANGE   24:20
`define FUNC7_ALT_BIT 30

// Major opcodes
`define OPCODE_LUI    7'b0110111
`define OPCODE_AUIPC  7'b0010111
`define OPCODE_JAL    7'b1101111
`define OPCODE_JALR   7'b1100111
`define OPCODE_BR     7'b1100011
`define OPCODE_L      7'b0000011
`define OPCODE_S      7'b0100011
`define OPCODE_ARITHI 7'b0010011
`define OPCODE_ARITH  7'b0110011

// Branch func3
`define FUNC3_BEQ  3'b000
`define FUNC3_BNE  3'b001
`define FUNC3_BLT  3'b100
`define FUNC3_BGE  3'b101
`define FUNC3_BLTU 3'b110
`define FUNC3_BGEU 3'b111

// Load func3
`define FUNC3_LB  3'b000
`define FUNC3_LH  3'b001
`define FUNC3_LW  3'b010
`define FUNC3_LBU 3'b100
`define FUNC3_LHU 3'b101

// Store func3
`define FUNC3_SB 3'b000
`define FUNC3_SH 3'b001
`define FUNC3_SW 3'b010

// ALU func3, shared by the register and immediate forms
`define FUNC3_ADD  3'b000
`define FUNC3_SLL  3'b001
`define FUNC3_SLT  3'b010
`define FUNC3_SLTU 3'b011
`define FUNC3_XOR  3'b100
`define FUNC3_SR   3'b101
`define FUNC3_OR   3'b110
`define FUNC3_AND  3'b111

`endif
